// ==== nccPkg.sv ====
package nccPkg;

	// pixel and row word geometry
	localparam int PIXEL_W = 8;
	localparam int COLS = 4;
	localparam int WORD_W = PIXEL_W * COLS;

	// log domain layout of one pixel
	localparam int EXP_W = 3;
	localparam int FRAC_W = 7;

	// exact product of two pixels never exceeds 16 bits
	localparam int PROD_W = 2 * PIXEL_W;

	// score and window index widths
	localparam int SCORE_W = 24;
	localparam int INDEX_W = 16;

	// Mitchell log of an unsigned pixel
	typedef struct packed {
		logic zero;
		logic [EXP_W-1:0] exp;
		logic [FRAC_W-1:0] frac;
	} logPixel_t;

	typedef logic [SCORE_W-1:0] score_t;

	// width of an index into n entries, never below one bit
	function automatic int idxWidth(input int n);
		int width;
		width = (n > 1) ? $clog2(n) : 1;
		return width;
	endfunction

endpackage

// ==== descWriteIf.sv ====
`timescale 1ns/1ps

interface descWriteIf #(
	parameter int ROWS = 4
);
	localparam int ROW_IDX_W = nccPkg::idxWidth(ROWS);

	// one descriptor row per write strobe
	logic write;
	logic [ROW_IDX_W-1:0] row;
	logic [nccPkg::WORD_W-1:0] word;

	// first row of a fresh descriptor
	logic clear;

	modport ctrl (
		output write,
		output row,
		output word,
		output clear
	);

	modport store (
		input write,
		input row,
		input word
	);

endinterface

// ==== pixelLog.sv ====
`timescale 1ns/1ps

module pixelLog (
	input logic [nccPkg::PIXEL_W-1:0] pixel,
	output nccPkg::logPixel_t logOut
);
	logic [nccPkg::PIXEL_W-1:0] stage1;
	logic [nccPkg::PIXEL_W-1:0] stage2;
	logic [nccPkg::PIXEL_W-1:0] stage3;
	logic [nccPkg::EXP_W-1:0] leadZeros;

	// halving search, upper nibble first
	always_comb begin
		if (pixel[nccPkg::PIXEL_W-1 -: 4] == '0) begin
			leadZeros[2] = 1'b1;
			stage1 = pixel << 4;
		end else begin
			leadZeros[2] = 1'b0;
			stage1 = pixel;
		end
		if (stage1[nccPkg::PIXEL_W-1 -: 2] == '0) begin
			leadZeros[1] = 1'b1;
			stage2 = stage1 << 2;
		end else begin
			leadZeros[1] = 1'b0;
			stage2 = stage1;
		end
		if (!stage2[nccPkg::PIXEL_W-1]) begin
			leadZeros[0] = 1'b1;
			stage3 = stage2 << 1;
		end else begin
			leadZeros[0] = 1'b0;
			stage3 = stage2;
		end
	end

	// leading one now sits at the top, the fraction is whatever follows it
	always_comb begin
		logOut.zero = (pixel == '0);
		logOut.exp = nccPkg::EXP_W'(nccPkg::PIXEL_W - 1) - leadZeros;
		logOut.frac = stage3[nccPkg::FRAC_W-1:0];
	end

endmodule

// ==== descriptorStore.sv ====
`timescale 1ns/1ps

module descriptorStore #(
	parameter int ROWS = 4
) (
	input logic clk,
	input logic rst,
	descWriteIf.store desc,
	output nccPkg::logPixel_t descLogs [ROWS][nccPkg::COLS]
);
	nccPkg::logPixel_t wordLogs [nccPkg::COLS];

	// convert the whole row word at once
	for (genvar c = 0; c < nccPkg::COLS; c++) begin : genConv
		pixelLog conv (
			.pixel(desc.word[c*nccPkg::PIXEL_W +: nccPkg::PIXEL_W]),
			.logOut(wordLogs[c])
		);
	end

	// row decode selects which bank of log registers takes the word
	for (genvar r = 0; r < ROWS; r++) begin : genRow
		logic rowSel;

		assign rowSel = desc.write && (desc.row == ($bits(desc.row))'(r));

		for (genvar c = 0; c < nccPkg::COLS; c++) begin : genCol
			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					descLogs[r][c] <= '0;
				end else if (rowSel) begin
					descLogs[r][c] <= wordLogs[c];
				end
			end
		end
	end

endmodule

// ==== processingElement.sv ====
`timescale 1ns/1ps

module processingElement (
	input logic clk,
	input logic rst,
	input logic loadWin,
	input nccPkg::logPixel_t winLogIn,
	input nccPkg::logPixel_t descLog,
	input nccPkg::score_t accIn,
	output nccPkg::score_t accOut
);
	// mantissa shifted by the largest possible exponent sum
	localparam int SHIFT_W = nccPkg::FRAC_W + (1 << (nccPkg::EXP_W + 1));

	nccPkg::logPixel_t winLog;
	logic [nccPkg::EXP_W:0] expSum;
	logic [nccPkg::FRAC_W:0] fracSum;
	logic [nccPkg::EXP_W:0] expAdj;
	logic [nccPkg::FRAC_W-1:0] fracAdj;
	logic [SHIFT_W-1:0] shifted;
	logic [nccPkg::PROD_W-1:0] product;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			winLog <= '0;
		end else if (loadWin) begin
			winLog <= winLogIn;
		end
	end

	// log add, then renormalize a fraction carry into the exponent
	always_comb begin
		expSum = {1'b0, descLog.exp} + {1'b0, winLog.exp};
		fracSum = {1'b0, descLog.frac} + {1'b0, winLog.frac};
		expAdj = expSum + {{nccPkg::EXP_W{1'b0}}, fracSum[nccPkg::FRAC_W]};
		fracAdj = fracSum[nccPkg::FRAC_W-1:0];
	end

	// antilog: restore the hidden one, shift up, drop the fraction bits
	always_comb begin
		shifted = SHIFT_W'({1'b1, fracAdj}) << expAdj;
		if (descLog.zero || winLog.zero) begin
			product = '0;
		end else begin
			product = shifted[nccPkg::FRAC_W +: nccPkg::PROD_W];
		end
	end

	assign accOut = accIn + nccPkg::score_t'(product);

endmodule

// ==== peArray.sv ====
`timescale 1ns/1ps

module peArray #(
	parameter int ROWS = 4
) (
	input logic clk,
	input logic rst,
	input logic [ROWS*nccPkg::WORD_W-1:0] winData,
	input logic loadWin,
	input logic captureSum,
	input nccPkg::logPixel_t descLogs [ROWS][nccPkg::COLS],
	output nccPkg::score_t sum
);
	nccPkg::logPixel_t winLogs [ROWS][nccPkg::COLS];
	nccPkg::score_t chain [ROWS][nccPkg::COLS+1];
	nccPkg::score_t total;

	for (genvar r = 0; r < ROWS; r++) begin : genRow
		// partial sum enters each row at zero
		assign chain[r][0] = '0;

		for (genvar c = 0; c < nccPkg::COLS; c++) begin : genCol
			localparam int K = r * nccPkg::COLS + c;

			pixelLog conv (
				.pixel(winData[K*nccPkg::PIXEL_W +: nccPkg::PIXEL_W]),
				.logOut(winLogs[r][c])
			);

			processingElement pe (
				.clk(clk),
				.rst(rst),
				.loadWin(loadWin),
				.winLogIn(winLogs[r][c]),
				.descLog(descLogs[r][c]),
				.accIn(chain[r][c]),
				.accOut(chain[r][c+1])
			);
		end
	end

	// row totals come out of the last column
	always_comb begin
		total = '0;
		for (int r = 0; r < ROWS; r++) begin
			total = total + chain[r][nccPkg::COLS];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sum <= '0;
		end else if (captureSum) begin
			sum <= total;
		end
	end

endmodule

// ==== bestScoreTracker.sv ====
`timescale 1ns/1ps

module bestScoreTracker (
	input logic clk,
	input logic rst,
	input logic clear,
	input logic capture,
	input nccPkg::score_t score,
	input logic [nccPkg::INDEX_W-1:0] index,
	output nccPkg::score_t bestScore,
	output logic [nccPkg::INDEX_W-1:0] bestIndex
);
	logic comparePending;

	// the score register fills on the capture edge,
	// so the comparison itself runs one edge later
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			comparePending <= 1'b0;
		end else begin
			comparePending <= capture;
		end
	end

	// strictly greater only, ties keep the earlier window
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			bestScore <= '0;
			bestIndex <= '0;
		end else if (clear) begin
			bestScore <= '0;
			bestIndex <= '0;
		end else if (comparePending && (score > bestScore)) begin
			bestScore <= score;
			bestIndex <= index;
		end
	end

endmodule

// ==== nccControl.sv ====
`timescale 1ns/1ps

module nccControl #(
	parameter int ROWS = 4
) (
	input logic clk,
	input logic rst,
	input logic descValid,
	output logic descReady,
	input logic [nccPkg::WORD_W-1:0] descData,
	input logic winValid,
	output logic winReady,
	output logic scoreValid,
	input logic scoreReady,
	descWriteIf.ctrl desc,
	output logic loadWin,
	output logic captureSum,
	output logic [nccPkg::INDEX_W-1:0] windowIndex
);
	localparam int ROW_IDX_W = nccPkg::idxWidth(ROWS);
	localparam logic [ROW_IDX_W-1:0] LAST_ROW = ROW_IDX_W'(ROWS - 1);

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		SCORE
	} state_t;

	state_t state;
	state_t nextState;
	logic [ROW_IDX_W-1:0] descRow;
	logic descComplete;
	logic descXfer;
	logic scoreXfer;

	assign descReady = (state == IDLE);
	// a pending descriptor word wins over a window in the same cycle
	assign winReady = (state == IDLE) && descComplete && !descValid;
	assign scoreValid = (state == SCORE);

	assign descXfer = descValid && descReady;
	assign loadWin = winValid && winReady;
	assign scoreXfer = scoreValid && scoreReady;
	assign captureSum = (state == LOAD);

	assign desc.write = descXfer;
	assign desc.row = descRow;
	assign desc.word = descData;
	assign desc.clear = descXfer && (descRow == '0);

	always_comb begin
		nextState = state;
		case (state)
			IDLE: if (loadWin) nextState = LOAD;
			LOAD: nextState = SCORE;
			SCORE: if (scoreXfer) nextState = IDLE;
			default: nextState = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	// row counter wraps so the next word opens a new descriptor
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			descRow <= '0;
			descComplete <= 1'b0;
		end else if (descXfer) begin
			descRow <= (descRow == LAST_ROW) ? '0 : descRow + 1'b1;
			descComplete <= (descRow == LAST_ROW);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			windowIndex <= '0;
		end else if (desc.clear) begin
			windowIndex <= '0;
		end else if (scoreXfer) begin
			windowIndex <= windowIndex + 1'b1;
		end
	end

endmodule

// ==== nccMatcher.sv ====
`timescale 1ns/1ps

module nccMatcher #(
	parameter int ROWS = 4
) (
	input logic clk,
	input logic rst,
	input logic descValid,
	output logic descReady,
	input logic [nccPkg::WORD_W-1:0] descData,
	input logic winValid,
	output logic winReady,
	input logic [ROWS*nccPkg::WORD_W-1:0] winData,
	output logic scoreValid,
	input logic scoreReady,
	output nccPkg::score_t score,
	output logic [nccPkg::INDEX_W-1:0] scoreIndex,
	output nccPkg::score_t bestScore,
	output logic [nccPkg::INDEX_W-1:0] bestIndex
);
	descWriteIf #(.ROWS(ROWS)) descBus ();

	nccPkg::logPixel_t descLogs [ROWS][nccPkg::COLS];
	logic loadWin;
	logic captureSum;

	nccControl #(.ROWS(ROWS)) control (
		.clk(clk),
		.rst(rst),
		.descValid(descValid),
		.descReady(descReady),
		.descData(descData),
		.winValid(winValid),
		.winReady(winReady),
		.scoreValid(scoreValid),
		.scoreReady(scoreReady),
		.desc(descBus.ctrl),
		.loadWin(loadWin),
		.captureSum(captureSum),
		.windowIndex(scoreIndex)
	);

	descriptorStore #(.ROWS(ROWS)) store (
		.clk(clk),
		.rst(rst),
		.desc(descBus.store),
		.descLogs(descLogs)
	);

	peArray #(.ROWS(ROWS)) array (
		.clk(clk),
		.rst(rst),
		.winData(winData),
		.loadWin(loadWin),
		.captureSum(captureSum),
		.descLogs(descLogs),
		.sum(score)
	);

	// best match resets with every new descriptor
	bestScoreTracker tracker (
		.clk(clk),
		.rst(rst),
		.clear(descBus.clear),
		.capture(captureSum),
		.score(score),
		.index(scoreIndex),
		.bestScore(bestScore),
		.bestIndex(bestIndex)
	);

endmodule

// ==== tbNccMatcher.sv ====
`timescale 1ns/1ps

module tbNccMatcher;

	localparam int ROWS = 4;
	localparam int WIN_W = ROWS * 32;
	localparam int TIMEOUT = 200;

	typedef struct packed {
		logic loadDesc;
		logic [WIN_W-1:0] descWords;
		logic [WIN_W-1:0] win;
		logic [7:0] stall;
		nccPkg::score_t expScore;
		nccPkg::score_t expBest;
		logic [15:0] expBestIdx;
		logic [15:0] expIndex;
	} testCase_t;

	logic clk;
	logic rst;
	logic descValid;
	logic descReady;
	logic [31:0] descData;
	logic winValid;
	logic winReady;
	logic [WIN_W-1:0] winData;
	logic scoreValid;
	logic scoreReady;
	nccPkg::score_t score;
	logic [15:0] scoreIndex;
	nccPkg::score_t bestScore;
	logic [15:0] bestIndex;

	testCase_t cases[$];
	logic [31:0] rngState;
	int errors;
	int casesRun;
	logic aborted;

	nccMatcher #(.ROWS(ROWS)) DUT (
		.clk(clk),
		.rst(rst),
		.descValid(descValid),
		.descReady(descReady),
		.descData(descData),
		.winValid(winValid),
		.winReady(winReady),
		.winData(winData),
		.scoreValid(scoreValid),
		.scoreReady(scoreReady),
		.score(score),
		.scoreIndex(scoreIndex),
		.bestScore(bestScore),
		.bestIndex(bestIndex)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Mitchell product of two pixels in the log domain
	function automatic int modelProduct(input logic [7:0] d, input logic [7:0] w);
		int ed;
		int ew;
		int e;
		int f;
		ed = 0;
		ew = 0;
		for (int b = 0; b < 8; b++) begin
			if (d[b]) ed = b;
			if (w[b]) ew = b;
		end
		if (d == 8'd0 || w == 8'd0) return 0;
		e = ed + ew;
		f = (((int'(d) - (1 << ed)) << (7 - ed)) + ((int'(w) - (1 << ew)) << (7 - ew)));
		if (f >= 128) begin
			e = e + 1;
			f = f - 128;
		end
		return ((128 + f) << e) >> 7;
	endfunction

	function automatic nccPkg::score_t modelScore(input logic [WIN_W-1:0] descWords,
		input logic [WIN_W-1:0] win);
		int total;
		total = 0;
		for (int k = 0; k < ROWS * 4; k++) begin
			total = total + modelProduct(descWords[8*k +: 8], win[8*k +: 8]);
		end
		return nccPkg::score_t'(total);
	endfunction

	task automatic randomPatch(output logic [WIN_W-1:0] patch);
		for (int i = 0; i < ROWS; i++) begin
			rngState = xorshift(rngState);
			patch[32*i +: 32] = rngState;
		end
	endtask

	task automatic addCase(input logic load, input logic [WIN_W-1:0] descWords,
		input logic [WIN_W-1:0] win, input int stall);
		testCase_t tc;
		tc = '0;
		tc.loadDesc = load;
		tc.descWords = descWords;
		tc.win = win;
		tc.stall = 8'(stall);
		cases.push_back(tc);
	endtask

	// expected scores, running best and window index per case
	task automatic fillExpected();
		testCase_t tc;
		logic [WIN_W-1:0] curDesc;
		nccPkg::score_t best;
		logic [15:0] bestIdx;
		logic [15:0] idx;
		curDesc = '0;
		best = '0;
		bestIdx = '0;
		idx = '0;
		for (int i = 0; i < cases.size(); i++) begin
			tc = cases[i];
			if (tc.loadDesc) begin
				curDesc = tc.descWords;
				best = '0;
				bestIdx = '0;
				idx = '0;
			end
			tc.expScore = modelScore(curDesc, tc.win);
			tc.expIndex = idx;
			if (tc.expScore > best) begin
				best = tc.expScore;
				bestIdx = idx;
			end
			tc.expBest = best;
			tc.expBestIdx = bestIdx;
			idx = idx + 16'd1;
			cases[i] = tc;
		end
	endtask

	task automatic buildTable();
		logic [WIN_W-1:0] patch;
		logic [WIN_W-1:0] fixedWin;
		fixedWin = 128'h01ff0080_00fe0002_ff000000_7f0040c3;
		// all 255 gives the fraction carry in every cell
		addCase(1'b1, {4{32'hffffffff}}, {4{32'hffffffff}}, 0);
		addCase(1'b0, '0, fixedWin, 2);
		// ties the first score so the best index stays 0
		addCase(1'b0, '0, {4{32'hffffffff}}, 0);
		addCase(1'b1, 128'h80402010_08040201_ff7f3f1f_c0a05030, fixedWin, 3);
		addCase(1'b0, '0, fixedWin, 0);
		randomPatch(patch);
		addCase(1'b0, '0, patch, 4);
		randomPatch(patch);
		addCase(1'b0, '0, patch, 0);
		addCase(1'b0, '0, '0, 1);
		randomPatch(patch);
		addCase(1'b1, patch, '0, 0);
		for (int i = 0; i < 3; i++) begin
			randomPatch(patch);
			addCase(1'b0, '0, patch, i * 2);
		end
		fillExpected();
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		errors++;
	endtask

	task automatic timeoutAbort(input string what);
		$display("timeout: %s never came within %0d cycles", what, TIMEOUT);
		errors++;
		aborted = 1'b1;
	endtask

	// one row word per transfer starting 1 ns after a rising edge
	task automatic loadDescriptor(input logic [WIN_W-1:0] words);
		int waitCount;
		for (int r = 0; r < ROWS; r++) begin
			descValid = 1'b1;
			descData = words[32*r +: 32];
			waitCount = 0;
			@(negedge clk);
			while (!descReady) begin
				waitCount++;
				if (waitCount > TIMEOUT) begin
					timeoutAbort("descReady");
					return;
				end
				@(negedge clk);
			end
			@(posedge clk);
			#1;
		end
		descValid = 1'b0;
		descData = '0;
	endtask

	task automatic runCase(input testCase_t tc);
		int waitCount;
		int latency;
		if (tc.loadDesc) begin
			loadDescriptor(tc.descWords);
			if (aborted) return;
			@(negedge clk);
			if (bestScore !== '0) reportMismatch("bestScore", bestScore, 0);
			if (bestIndex !== '0) reportMismatch("bestIndex", bestIndex, 0);
			if (scoreIndex !== '0) reportMismatch("scoreIndex", scoreIndex, 0);
			@(posedge clk);
			#1;
		end
		winValid = 1'b1;
		winData = tc.win;
		waitCount = 0;
		@(negedge clk);
		while (!winReady) begin
			waitCount++;
			if (waitCount > TIMEOUT) begin
				timeoutAbort("winReady");
				return;
			end
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		winValid = 1'b0;
		winData = '0;
		// the transfer edge counts as the first cycle
		latency = 1;
		@(negedge clk);
		while (!scoreValid) begin
			latency++;
			if (latency > TIMEOUT) begin
				timeoutAbort("scoreValid");
				return;
			end
			@(negedge clk);
		end
		if (latency != 2) reportMismatch("scoreValid latency", latency, 2);
		if (score !== tc.expScore) reportMismatch("score", score, tc.expScore);
		if (scoreIndex !== tc.expIndex) begin
			reportMismatch("scoreIndex", scoreIndex, tc.expIndex);
		end
		// outputs hold under back-pressure
		for (int s = 0; s < int'(tc.stall); s++) begin
			@(negedge clk);
			if (scoreValid !== 1'b1) reportMismatch("scoreValid", scoreValid, 1);
			if (winReady !== 1'b0) reportMismatch("winReady", winReady, 0);
			if (score !== tc.expScore) reportMismatch("score", score, tc.expScore);
			if (scoreIndex !== tc.expIndex) begin
				reportMismatch("scoreIndex", scoreIndex, tc.expIndex);
			end
		end
		@(posedge clk);
		#1;
		scoreReady = 1'b1;
		@(posedge clk);
		#1;
		scoreReady = 1'b0;
		@(negedge clk);
		if (scoreValid !== 1'b0) reportMismatch("scoreValid", scoreValid, 0);
		if (winReady !== 1'b1) reportMismatch("winReady", winReady, 1);
		if (scoreIndex !== tc.expIndex + 16'd1) begin
			reportMismatch("scoreIndex", scoreIndex, tc.expIndex + 16'd1);
		end
		if (bestScore !== tc.expBest) reportMismatch("bestScore", bestScore, tc.expBest);
		if (bestIndex !== tc.expBestIdx) begin
			reportMismatch("bestIndex", bestIndex, tc.expBestIdx);
		end
		@(posedge clk);
		#1;
	endtask

	initial begin
		rst = 1'b1;
		descValid = 1'b0;
		descData = '0;
		winValid = 1'b0;
		winData = '0;
		scoreReady = 1'b0;
		errors = 0;
		casesRun = 0;
		aborted = 1'b0;
		rngState = 32'h93ab;
		buildTable();
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		if (descReady !== 1'b1) reportMismatch("descReady", descReady, 1);
		if (winReady !== 1'b0) reportMismatch("winReady", winReady, 0);
		if (scoreValid !== 1'b0) reportMismatch("scoreValid", scoreValid, 0);
		if (bestScore !== '0) reportMismatch("bestScore", bestScore, 0);
		@(posedge clk);
		#1;
		for (int i = 0; i < cases.size(); i++) begin
			runCase(cases[i]);
			casesRun++;
			if (aborted) break;
		end
		$display("cases run: %0d, errors: %0d", casesRun, errors);
		if (errors == 0 && !aborted) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== src.f ====
nccPkg.sv
descWriteIf.sv
pixelLog.sv
descriptorStore.sv
processingElement.sv
peArray.sv
bestScoreTracker.sv
nccControl.sv
nccMatcher.sv
tbNccMatcher.sv

// ==== Makefile ====
SOURCES = $(shell cat src.f)

obj_dir/VtbNccMatcher: src.f $(SOURCES)
	verilator --binary --timing -Wno-fatal --top-module tbNccMatcher -f src.f

run: obj_dir/VtbNccMatcher
	@out="$$(./obj_dir/VtbNccMatcher)"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

.PHONY: run clean
